// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check sim.log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing -f sim.f --top-module gbAluCoreTb -Mdir obj_dir -o gbAluCoreTb
	./obj_dir/gbAluCoreTb | tee sim.log
	@grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== sim.f ====
+incdir+tb
source/gbCorePkg.sv
source/opDecoder.sv
source/aluExecute.sv
source/regWriteback.sv
source/gbAluCore.sv
tb/gbAluCoreTb.sv

// ==== source/aluExecute.sv ====
`default_nettype none

module aluExecute import gbCorePkg::*;
(
  input  logic       decValid,
  input  decodedOpT  decoded,
  input  logic [7:0] srcValue,
  input  logic [7:0] accValue,
  input  flagsT      curFlags,
  output regIdxT     srcIdx,
  output logic       exeValid,
  output resultT     exeResult
);

  logic [7:0] operand;
  logic       carryIn;
  logic [8:0] sum9;
  logic [8:0] diff9;
  logic [4:0] sumLo;
  logic [4:0] diffLo;
  logic [7:0] value;
  flagsT      flags;

  assign srcIdx  = decoded.src;
  assign operand = (decoded.kind == LOAD_IMM) ? decoded.imm : srcValue;

  // Old carry only feeds ADC and SBC
  assign carryIn = curFlags.c &
                   ((decoded.aluOp == ALU_ADC) || (decoded.aluOp == ALU_SBC));

  // ----------------------------------------------------------------------
  // Carry and nibble paths
  // ----------------------------------------------------------------------
  assign sum9   = {1'b0, accValue} + {1'b0, operand} + {8'd0, carryIn};
  assign diff9  = {1'b0, accValue} - {1'b0, operand} - {8'd0, carryIn};
  assign sumLo  = {1'b0, accValue[3:0]} + {1'b0, operand[3:0]} + {4'd0, carryIn};
  assign diffLo = {1'b0, accValue[3:0]} - {1'b0, operand[3:0]} - {4'd0, carryIn};

  // ----------------------------------------------------------------------
  // Result value and flags
  // ----------------------------------------------------------------------
  always_comb
  begin
    value = operand;    // Loads
    flags = curFlags;   // Loads keep F

    if (decoded.kind == ALU)
    begin
      flags = '0;
      case (decoded.aluOp)
        ALU_ADD, ALU_ADC:
        begin
          value   = sum9[7:0];
          flags.h = sumLo[4];      // Carry out of bit 3
          flags.c = sum9[8];
        end
        ALU_SUB, ALU_SBC, ALU_CP:
        begin
          value   = diff9[7:0];
          flags.n = 1'b1;
          flags.h = diffLo[4];     // Borrow from bit 4
          flags.c = diff9[8];
        end
        ALU_AND:
        begin
          value   = accValue & operand;
          flags.h = 1'b1;
        end
        ALU_XOR:
        begin
          value = accValue ^ operand;
        end
        default:
        begin
          value = accValue | operand;   // OR
        end
      endcase
      flags.z = (value == 8'd0);
    end
  end

  assign exeValid = decValid;

  always_comb
  begin
    exeResult.dst     = decoded.dst;
    exeResult.writeEn = decoded.writeEn;
    exeResult.value   = value;
    exeResult.flags   = flags;
  end

endmodule

`default_nettype wire

// ==== source/gbAluCore.sv ====
`default_nettype none

module gbAluCore import gbCorePkg::*;
#(
  parameter logic [7:0] FlagsInit = 8'hB0
)
(
  input  logic       iClock,
  input  logic       arstN,
  input  logic       opValid,
  input  opcodeU     opcode,
  input  logic [7:0] immData,
  output logic       resValid,
  output resultT     result
);

  logic       decValid;
  decodedOpT  decoded;
  regIdxT     srcIdx;
  logic [7:0] srcValue;
  logic [7:0] accValue;
  flagsT      curFlags;
  logic       exeValid;
  resultT     exeResult;

  // Decode, one cycle
  opDecoder opDecoder_i (
    .iClock   (iClock),
    .arstN    (arstN),
    .opValid  (opValid),
    .opcode   (opcode),
    .immData  (immData),
    .decValid (decValid),
    .decoded  (decoded)
  );

  // Execute, combinational
  aluExecute aluExecute_i (
    .decValid  (decValid),
    .decoded   (decoded),
    .srcValue  (srcValue),
    .accValue  (accValue),
    .curFlags  (curFlags),
    .srcIdx    (srcIdx),
    .exeValid  (exeValid),
    .exeResult (exeResult)
  );

  regWriteback #(
    .FlagsInit (FlagsInit)
  ) regWriteback_i (
    .iClock    (iClock),
    .arstN     (arstN),
    .exeValid  (exeValid),
    .exeResult (exeResult),
    .srcIdx    (srcIdx),
    .srcValue  (srcValue),
    .accValue  (accValue),
    .curFlags  (curFlags),
    .resValid  (resValid),
    .result    (result)
  );

endmodule

`default_nettype wire

// ==== source/gbCorePkg.sv ====
`default_nettype none

package gbCorePkg;

  // ----------------------------------------------------------------------
  // Opcode field encodings
  // ----------------------------------------------------------------------

  // Register codes in opcode order, M is the (HL) memory operand
  typedef enum logic [2:0] {
    REG_B = 3'd0,
    REG_C = 3'd1,
    REG_D = 3'd2,
    REG_E = 3'd3,
    REG_H = 3'd4,
    REG_L = 3'd5,
    REG_M = 3'd6,
    REG_A = 3'd7
  } regIdxT;

  // Opcode bits 5:3 of the 0x80-0xBF block
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_ADC = 3'd1,
    ALU_SUB = 3'd2,
    ALU_SBC = 3'd3,
    ALU_AND = 3'd4,
    ALU_XOR = 3'd5,
    ALU_OR  = 3'd6,
    ALU_CP  = 3'd7
  } aluOpT;

  typedef enum logic [1:0] {
    LOAD_REG = 2'd0,
    LOAD_IMM = 2'd1,
    ALU      = 2'd2
  } opKindT;

  // Same layout as the F register
  typedef struct packed {
    logic       z;
    logic       n;
    logic       h;
    logic       c;
    logic [3:0] zero;
  } flagsT;

  typedef struct packed {
    logic [1:0] prefix;
    regIdxT     dst;
    regIdxT     src;
  } ldFieldsT;

  typedef struct packed {
    logic [1:0] prefix;
    aluOpT      op;
    regIdxT     src;
  } aluFieldsT;

  // One opcode byte, read as a load or as an ALU op
  typedef union packed {
    ldFieldsT  ld;
    aluFieldsT alu;
  } opcodeU;

  // ----------------------------------------------------------------------
  // Stage payloads
  // ----------------------------------------------------------------------

  typedef struct packed {
    opKindT     kind;
    aluOpT      aluOp;
    regIdxT     dst;
    regIdxT     src;
    logic [7:0] imm;
    logic       writeEn;
  } decodedOpT;

  typedef struct packed {
    regIdxT     dst;
    logic       writeEn;
    logic [7:0] value;
    flagsT      flags;
  } resultT;

endpackage

`default_nettype wire

// ==== source/opDecoder.sv ====
`default_nettype none

module opDecoder import gbCorePkg::*;
(
  input  logic       iClock,
  input  logic       arstN,
  input  logic       opValid,
  input  opcodeU     opcode,
  input  logic [7:0] immData,
  output logic       decValid,
  output decodedOpT  decoded
);

  logic      accept;
  decodedOpT nextOp;

  // ----------------------------------------------------------------------
  // Classify the opcode byte
  // ----------------------------------------------------------------------
  always_comb
  begin
    accept         = 1'b0;
    nextOp.kind    = LOAD_REG;
    nextOp.aluOp   = opcode.alu.op;
    nextOp.dst     = opcode.ld.dst;
    nextOp.src     = opcode.ld.src;
    nextOp.imm     = immData;
    nextOp.writeEn = 1'b1;

    case (opcode.ld.prefix)
      2'b00:
      begin
        // LD r,n is 00rrr110, LD (HL),n rejected
        accept      = (opcode.ld.src == REG_M) && (opcode.ld.dst != REG_M);
        nextOp.kind = LOAD_IMM;
      end
      2'b01:
      begin
        // Also drops 0x76 since dst is M there
        accept = (opcode.ld.dst != REG_M) && (opcode.ld.src != REG_M);
      end
      2'b10:
      begin
        accept         = (opcode.alu.src != REG_M);
        nextOp.kind    = ALU;
        nextOp.dst     = REG_A;                    // All ALU ops target A
        nextOp.writeEn = (opcode.alu.op != ALU_CP);
      end
      default:
      begin
        accept = 1'b0;
      end
    endcase
  end

  // ----------------------------------------------------------------------
  // Decode register
  // ----------------------------------------------------------------------
  always_ff @(posedge iClock or negedge arstN)
  begin
    if (!arstN)
    begin
      decValid <= 1'b0;
    end
    else
    begin
      decValid <= opValid & accept;
    end
  end

  always_ff @(posedge iClock)
  begin
    if (opValid && accept)
    begin
      decoded <= nextOp;
    end
  end

endmodule

`default_nettype wire

// ==== source/regWriteback.sv ====
`default_nettype none

module regWriteback import gbCorePkg::*;
#(
  parameter logic [7:0] FlagsInit = 8'hB0
)
(
  input  logic       iClock,
  input  logic       arstN,
  input  logic       exeValid,
  input  resultT     exeResult,
  input  regIdxT     srcIdx,
  output logic [7:0] srcValue,
  output logic [7:0] accValue,
  output flagsT      curFlags,
  output logic       resValid,
  output resultT     result
);

  // B to L at their own codes, A in slot 6
  logic [7:0] regFile [7];
  flagsT      flagsQ;

  function automatic logic [2:0] slotOf(input regIdxT idx);
    return (idx == REG_A) ? 3'd6 : idx;
  endfunction

  assign srcValue = regFile[slotOf(srcIdx)];
  assign accValue = regFile[slotOf(REG_A)];
  assign curFlags = flagsQ;

  // ----------------------------------------------------------------------
  // Register bank and F
  // ----------------------------------------------------------------------
  always_ff @(posedge iClock or negedge arstN)
  begin
    if (!arstN)
    begin
      for (int i = 0; i < 7; i++)
      begin
        regFile[i] <= 8'd0;
      end
      flagsQ <= {FlagsInit[7:4], 4'd0};
    end
    else if (exeValid)
    begin
      if (exeResult.writeEn)
      begin
        regFile[slotOf(exeResult.dst)] <= exeResult.value;
      end
      flagsQ <= {exeResult.flags[7:4], 4'd0};   // Low nibble stays 0
    end
  end

  // ----------------------------------------------------------------------
  // Result output
  // ----------------------------------------------------------------------
  always_ff @(posedge iClock or negedge arstN)
  begin
    if (!arstN)
    begin
      resValid <= 1'b0;
    end
    else
    begin
      resValid <= exeValid;
    end
  end

  always_ff @(posedge iClock)
  begin
    if (exeValid)
    begin
      result <= exeResult;
    end
  end

endmodule

`default_nettype wire

// ==== tb/gbRefModel.svh ====
`ifndef GB_REF_MODEL_SVH
`define GB_REF_MODEL_SVH

// ----------------------------------------------------------------------
// Reference model of the register bank, F and the opcode rules
// ----------------------------------------------------------------------

logic [7:0] modelRegs [8];
flagsT      modelFlags;

function automatic void modelReset(input logic [7:0] flagsInit);
  for (int i = 0; i < 8; i++)
  begin
    modelRegs[i] = 8'd0;
  end
  modelFlags = {flagsInit[7:4], 4'd0};
endfunction

// Applies one opcode, returns 1 and the expected result if it is accepted
function automatic logic modelApply(input logic [7:0] op, input logic [7:0] imm,
                                    output resultT exp);
  int         a;
  int         b;
  int         cin;
  int         full;
  logic [2:0] dstCode;
  logic [2:0] srcCode;
  logic [7:0] val;
  flagsT      f;

  dstCode = op[5:3];
  srcCode = op[2:0];
  exp     = '0;
  f       = modelFlags;
  a       = int'(modelRegs[7]);
  b       = int'(modelRegs[srcCode]);
  cin     = 0;

  if (op[7:6] == 2'b00)
  begin
    if (srcCode != 3'd6 || dstCode == 3'd6)
      return 1'b0;
    val = imm;                                  // LD r,n
  end
  else if (op[7:6] == 2'b01)
  begin
    if (dstCode == 3'd6 || srcCode == 3'd6)
      return 1'b0;
    val = modelRegs[srcCode];
  end
  else if (op[7:6] == 2'b10)
  begin
    if (srcCode == 3'd6)
      return 1'b0;
    if (dstCode == 3'd1 || dstCode == 3'd3)
      cin = int'(modelFlags.c);                 // ADC and SBC
    f = '0;
    case (dstCode)
      3'd0, 3'd1:
      begin
        full = a + b + cin;
        val  = full[7:0];
        f.h  = ((a & 15) + (b & 15) + cin) > 15;
        f.c  = full > 255;
      end
      3'd2, 3'd3, 3'd7:
      begin
        full = a - b - cin;
        val  = full[7:0];
        f.n  = 1'b1;
        f.h  = (a & 15) < ((b & 15) + cin);
        f.c  = a < (b + cin);
      end
      3'd4:
      begin
        val = modelRegs[7] & modelRegs[srcCode];
        f.h = 1'b1;
      end
      3'd5:    val = modelRegs[7] ^ modelRegs[srcCode];
      default: val = modelRegs[7] | modelRegs[srcCode];
    endcase
    f.z     = (val == 8'd0);
    dstCode = 3'd7;                             // ALU always targets A
  end
  else
  begin
    return 1'b0;
  end

  exp.dst     = regIdxT'(dstCode);
  exp.writeEn = !(op[7:6] == 2'b10 && op[5:3] == 3'd7);   // CP keeps A
  exp.value   = val;
  exp.flags   = f;
  if (exp.writeEn)
    modelRegs[dstCode] = val;
  modelFlags = f;
  return 1'b1;
endfunction

`endif

// ==== tb/gbAluCoreTb.sv ====
`default_nettype none

module gbAluCoreTb import gbCorePkg::*;
();

  localparam int NumCycles = 400;
  localparam int ClkPeriod = 8;
  localparam logic [7:0] FlagsInit = 8'hB0;

  logic       iClock = 1'b0;
  logic       arstN;
  logic       opValid;
  opcodeU     opcode;
  logic [7:0] immData;
  logic       resValid;
  resultT     result;

  resultT expQ [$];
  int     cycleQ [$];
  int     cycleCnt = 0;
  int     resultErrors = 0;
  int     flagErrors = 0;
  int     otherErrors = 0;

  `include "gbRefModel.svh"

  gbAluCore #(
    .FlagsInit (FlagsInit)
  ) gbAluCore_i (
    .iClock   (iClock),
    .arstN    (arstN),
    .opValid  (opValid),
    .opcode   (opcode),
    .immData  (immData),
    .resValid (resValid),
    .result   (result)
  );

  initial
  begin
    forever #(ClkPeriod / 2) iClock = ~iClock;
  end

  always @(posedge iClock) cycleCnt <= cycleCnt + 1;

  // ----------------------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------------------
  task automatic checkResult(input resultT exp, input resultT act);
    if (act.dst !== exp.dst || act.writeEn !== exp.writeEn || act.value !== exp.value)
    begin
      $display("** Error at %0t: result expected dst %0d we %0b value %02h, actual %0d %0b %02h",
               $time, exp.dst, exp.writeEn, exp.value, act.dst, act.writeEn, act.value);
      resultErrors++;
    end
  endtask

  task automatic checkFlags(input flagsT exp, input flagsT act);
    if (act !== exp)
    begin
      $display("** Error at %0t: result.flags expected %02h, actual %02h", $time, exp, act);
      flagErrors++;
    end
  endtask

  // Results are stable at the falling edge
  always @(negedge iClock)
  begin
    if (arstN && resValid)
    begin
      if (expQ.size() == 0)
      begin
        $display("Result at %0t with no accepted opcode pending", $time);
        otherErrors++;
      end
      else
      begin
        if (cycleCnt != cycleQ[0])
        begin
          $display("Result at %0t came in cycle %0d instead of cycle %0d",
                   $time, cycleCnt, cycleQ[0]);
          otherErrors++;
        end
        checkResult(expQ[0], result);
        checkFlags(expQ[0].flags, result.flags);
        void'(expQ.pop_front());
        void'(cycleQ.pop_front());
      end
    end
  end

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------
  function automatic logic [2:0] randomReg();
    int r;
    r = $urandom_range(6, 0);
    return (r == 6) ? 3'd7 : r[2:0];    // Never the (HL) code
  endfunction

  function automatic logic [7:0] randomKeptOpcode();
    int kind;
    kind = $urandom_range(2, 0);
    if (kind == 0)
      return {2'b01, randomReg(), randomReg()};
    else if (kind == 1)
      return {2'b00, randomReg(), 3'b110};
    else
      return {2'b10, 3'($urandom_range(7, 0)), randomReg()};
  endfunction

  task automatic driveCycle(input logic valid, input logic [7:0] op, input logic [7:0] imm);
    resultT exp;
    @(posedge iClock);
    #1;
    opValid = valid;
    opcode  = op;
    immData = imm;
    if (valid)
    begin
      if (modelApply(op, imm, exp))
      begin
        expQ.push_back(exp);
        cycleQ.push_back(cycleCnt + 2);
      end
    end
  endtask

  initial
  begin
    int rnd;
    int drain;
    logic [7:0] op;

    void'($urandom(29033));
    arstN   = 1'b0;
    opValid = 1'b0;
    opcode  = '0;
    immData = 8'd0;
    modelReset(FlagsInit);
    repeat (2) @(posedge iClock);
    #1;
    arstN = 1'b1;

    driveCycle(1'b1, 8'h78, 8'h00);     // LD A,B right after reset
    driveCycle(1'b1, 8'h76, 8'h00);     // HALT slot, ignored
    driveCycle(1'b1, 8'h36, 8'h5A);     // LD (HL),n, ignored
    for (int i = 3; i < NumCycles; i++)
    begin
      rnd = $urandom;
      op  = ($urandom_range(99, 0) < 85) ? randomKeptOpcode() : rnd[7:0];
      driveCycle($urandom_range(99, 0) < 75, op, rnd[15:8]);
    end
    driveCycle(1'b0, 8'h00, 8'h00);

    drain = 0;
    while (expQ.size() != 0 && drain < 6)
    begin
      @(negedge iClock);
      drain++;
    end
    if (expQ.size() != 0)
    begin
      $display("%0d expected results never arrived", expQ.size());
      otherErrors += expQ.size();
    end

    $display("Errors: result %0d, flags %0d, other %0d", resultErrors, flagErrors, otherErrors);
    if (resultErrors + flagErrors + otherErrors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

  initial
  begin
    #(NumCycles * ClkPeriod + 100);
    $display("Watchdog expired before the stimulus and drain completed");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
